// ==== Makefile ====
# Verilator build and run of the lcd controller testbench

TOP := tb_lcd_ctrl

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f hdl/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

# pass only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/lcd_ctrl.sv ====
// lcd controller top level
// cpu register file, line timing, oam and its dma engine

`timescale 1ns/1ps

module lcd_ctrl (
	input  logic                clk_reg,
	input  logic                reset,
	input  logic                sel_reg,
	input  logic                sel_oam,
	input  logic                cpu_wr,
	input  logic [7:0]          cpu_addr,
	input  logic [7:0]          cpu_di,
	input  logic [7:0]          dma_data,
	output logic [7:0]          cpu_do,
	output logic                dma_rd,
	output logic                irq,
	output logic                vblank_irq,
	output logic                lcd_on,
	output logic [15:0]         dma_addr,
	output lcd_pkg::mode_t      mode
);

	lcd_pkg::lcdc_t lcdc;
	logic [7:0]     scx;
	logic [7:0]     lyc;
	logic [7:0]     ly;
	logic [7:0]     dma_page;
	logic [7:0]     oam_do;
	logic [7:0]     oam_waddr;
	logic [3:0]     stat_ena;
	logic           lyc_match;
	logic           dma_start;
	logic           dma_active;
	logic           oam_we;

	// ----------------------------------------------------------------------
	lcd_timing u_lcd_timing (
		.clk_reg(clk_reg), .reset(reset), .lcdc(lcdc), .scx(scx), .lyc(lyc),
		.stat_ena(stat_ena), .ly(ly), .mode(mode), .lyc_match(lyc_match),
		.irq(irq), .vblank_irq(vblank_irq)
	);

	lcd_regs u_lcd_regs (
		.clk_reg(clk_reg), .reset(reset), .sel_reg(sel_reg), .sel_oam(sel_oam),
		.cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_di(cpu_di), .ly(ly), .mode(mode),
		.lyc_match(lyc_match), .oam_do(oam_do), .cpu_do(cpu_do), .lcdc(lcdc),
		.scx(scx), .lyc(lyc), .dma_page(dma_page), .stat_ena(stat_ena),
		.dma_start(dma_start)
	);

	// dma engine and the oam it fills
	oam_dma u_oam_dma (
		.clk_reg(clk_reg), .reset(reset), .dma_start(dma_start), .dma_page(dma_page),
		.dma_data(dma_data), .dma_active(dma_active), .dma_addr(dma_addr),
		.oam_waddr(oam_waddr), .oam_we(oam_we)
	);

	oam_ram u_oam_ram (
		.clk_reg(clk_reg), .sel_oam(sel_oam), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
		.cpu_di(cpu_di), .mode(mode), .dma_active(dma_active), .oam_we(oam_we),
		.oam_waddr(oam_waddr), .dma_data(dma_data), .oam_do(oam_do)
	);

	// memory read strobe follows the dma window
	assign dma_rd = dma_active;
	assign lcd_on = lcdc.f.lcd_on;

endmodule

// ==== hdl/lcd_pkg.sv ====
// lcd controller shared definitions
// register map, line/frame timing constants, oam dma sizes
// and the lcdc control byte with its flag view

package lcd_pkg;

	// stat mode field
	typedef logic [1:0] mode_t;

	// lcdc flag layout, bit 7 down to bit 0
	typedef struct packed {
		logic lcd_on;
		logic win_map;
		logic win_ena;
		logic tile_sel;
		logic bg_map;
		logic spr_size;
		logic spr_ena;
		logic bg_ena;
	} lcdc_flags_t;

	// cpu writes the raw byte, timing reads the flags
	typedef union packed {
		logic [7:0]  raw;
		lcdc_flags_t f;
	} lcdc_t;

	// ----------------------------------------------------------------------
	// line and frame timing
	localparam logic [8:0] LINE_LAST   = 9'd455;
	localparam logic [7:0] FRAME_LAST  = 8'd153;
	localparam logic [7:0] VBLANK_LINE = 8'd144;
	localparam logic [8:0] OAM_LEN     = 9'd80;
	localparam logic [8:0] MODE3_BASE  = 9'd256;
	localparam logic [8:0] SCX_EXTRA   = 9'd8;
	localparam logic [8:0] LATCH_H     = 9'd78;
	localparam logic [8:0] LCD_OFF_H   = 9'd4;

	// oam size and dma length, 4 cycles per byte
	localparam logic [7:0] OAM_SIZE = 8'd160;
	localparam logic [9:0] DMA_LEN  = 10'd640;

	// ----------------------------------------------------------------------
	// register addresses, low byte of 0xff4x
	localparam logic [7:0] ADDR_LCDC = 8'h40;
	localparam logic [7:0] ADDR_STAT = 8'h41;
	localparam logic [7:0] ADDR_SCY  = 8'h42;
	localparam logic [7:0] ADDR_SCX  = 8'h43;
	localparam logic [7:0] ADDR_LY   = 8'h44;
	localparam logic [7:0] ADDR_LYC  = 8'h45;
	localparam logic [7:0] ADDR_DMA  = 8'h46;
	localparam logic [7:0] ADDR_BGP  = 8'h47;
	localparam logic [7:0] ADDR_OBP0 = 8'h48;
	localparam logic [7:0] ADDR_OBP1 = 8'h49;
	localparam logic [7:0] ADDR_WY   = 8'h4A;
	localparam logic [7:0] ADDR_WX   = 8'h4B;

	// stat modes
	localparam mode_t MODE_HBLANK = 2'd0;
	localparam mode_t MODE_VBLANK = 2'd1;
	localparam mode_t MODE_OAM    = 2'd2;
	localparam mode_t MODE_XFER   = 2'd3;

endpackage

// ==== hdl/lcd_regs.sv ====
// lcd cpu register file
// 0x40..0x4b registers, cpu read multiplexer including oam data
// and the dma start strobe

`timescale 1ns/1ps

module lcd_regs (
	input  logic                clk_reg,
	input  logic                reset,
	input  logic                sel_reg,
	input  logic                sel_oam,
	input  logic                cpu_wr,
	input  logic [7:0]          cpu_addr,
	input  logic [7:0]          cpu_di,
	input  logic [7:0]          ly,
	input  lcd_pkg::mode_t      mode,
	input  logic                lyc_match,
	input  logic [7:0]          oam_do,
	output logic [7:0]          cpu_do,
	output lcd_pkg::lcdc_t      lcdc,
	output logic [7:0]          scx,
	output logic [7:0]          lyc,
	output logic [7:0]          dma_page,
	output logic [3:0]          stat_ena,
	output logic                dma_start
);

	logic [7:0] scy;
	logic [7:0] bgp;
	logic [7:0] obp0;
	logic [7:0] obp1;
	logic [7:0] wy;
	logic [7:0] wx;
	logic [7:0] reg_do;
	logic       reg_we;

	assign reg_we = sel_reg && cpu_wr;

	// ----------------------------------------------------------------------
	// register writes
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcd starts off
			lcdc.raw <= 8'h00;
			stat_ena <= 4'h0;
			scy <= 8'h00;
			scx <= 8'h00;
			lyc <= 8'h00;
			dma_page <= 8'h00;
			bgp <= 8'hFC;
			obp0 <= 8'hFF;
			obp1 <= 8'hFF;
			wy <= 8'h00;
			wx <= 8'h00;
		end else if (reg_we) begin
			case (cpu_addr)
				lcd_pkg::ADDR_LCDC: lcdc.raw <= cpu_di;
				// only the enable bits of stat are writable
				lcd_pkg::ADDR_STAT: stat_ena <= cpu_di[6:3];
				lcd_pkg::ADDR_SCY:  scy <= cpu_di;
				lcd_pkg::ADDR_SCX:  scx <= cpu_di;
				lcd_pkg::ADDR_LYC:  lyc <= cpu_di;
				lcd_pkg::ADDR_DMA:  dma_page <= cpu_di;
				lcd_pkg::ADDR_BGP:  bgp <= cpu_di;
				lcd_pkg::ADDR_OBP0: obp0 <= cpu_di;
				lcd_pkg::ADDR_OBP1: obp1 <= cpu_di;
				lcd_pkg::ADDR_WY:   wy <= cpu_di;
				lcd_pkg::ADDR_WX:   wx <= cpu_di;
				default: ;
			endcase
		end
	end

	// dma kicks off the cycle after the page is written
	always_ff @(posedge clk_reg) begin
		if (reset)
			dma_start <= 1'b0;
		else
			dma_start <= reg_we && (cpu_addr == lcd_pkg::ADDR_DMA);
	end

	// ----------------------------------------------------------------------
	// read multiplexer, unmapped addresses float high
	always_comb begin
		case (cpu_addr)
			lcd_pkg::ADDR_LCDC: reg_do = lcdc.raw;
			lcd_pkg::ADDR_STAT: reg_do = {1'b1, stat_ena, lyc_match, mode};
			lcd_pkg::ADDR_SCY:  reg_do = scy;
			lcd_pkg::ADDR_SCX:  reg_do = scx;
			lcd_pkg::ADDR_LY:   reg_do = ly;
			lcd_pkg::ADDR_LYC:  reg_do = lyc;
			lcd_pkg::ADDR_DMA:  reg_do = dma_page;
			lcd_pkg::ADDR_BGP:  reg_do = bgp;
			lcd_pkg::ADDR_OBP0: reg_do = obp0;
			lcd_pkg::ADDR_OBP1: reg_do = obp1;
			lcd_pkg::ADDR_WY:   reg_do = wy;
			lcd_pkg::ADDR_WX:   reg_do = wx;
			default:            reg_do = 8'hFF;
		endcase
	end

	// oam select overrides the register space
	assign cpu_do = sel_oam ? oam_do : reg_do;

endmodule

// ==== hdl/lcd_timing.sv ====
// lcd line/frame timing
// horizontal and vertical counters, stat mode, ly/lyc compare
// and the stat and vblank interrupt pulses

`timescale 1ns/1ps

module lcd_timing (
	input  logic                clk_reg,
	input  logic                reset,
	input  lcd_pkg::lcdc_t      lcdc,
	input  logic [7:0]          scx,
	input  logic [7:0]          lyc,
	input  logic [3:0]          stat_ena,
	output logic [7:0]          ly,
	output lcd_pkg::mode_t      mode,
	output logic                lyc_match,
	output logic                irq,
	output logic                vblank_irq
);

	logic [8:0] h_cnt;
	logic [7:0] scx_r;
	logic [8:0] hblank_h;
	logic       visible;
	logic       src_lyc;
	logic       src_oam;
	logic       src_vbl;
	logic       src_hbl;

	// ----------------------------------------------------------------------
	// counters, held while the lcd is off
	always_ff @(posedge clk_reg) begin
		if (reset || !lcdc.f.lcd_on) begin
			h_cnt <= lcd_pkg::LCD_OFF_H;
			ly <= 8'd0;
			scx_r <= 8'd0;
		end else begin
			// scx is sampled just before the transfer phase
			if (h_cnt == lcd_pkg::LATCH_H)
				scx_r <= scx;
			if (h_cnt == lcd_pkg::LINE_LAST) begin
				h_cnt <= 9'd0;
				if (ly == lcd_pkg::FRAME_LAST)
					ly <= 8'd0;
				else
					ly <= ly + 8'd1;
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
		end
	end

	// fine scroll costs one more tile fetch, so hblank starts later
	assign hblank_h = (scx_r[2:0] != 3'd0) ? lcd_pkg::MODE3_BASE + lcd_pkg::SCX_EXTRA
		: lcd_pkg::MODE3_BASE;

	assign visible = (ly < lcd_pkg::VBLANK_LINE);
	assign lyc_match = (ly == lyc);

	// ----------------------------------------------------------------------
	// stat mode
	always_comb begin
		if (!lcdc.f.lcd_on)
			mode = lcd_pkg::MODE_HBLANK;
		// first cycles of a line still report hblank
		else if (h_cnt < lcd_pkg::LCD_OFF_H && ly <= lcd_pkg::VBLANK_LINE)
			mode = lcd_pkg::MODE_HBLANK;
		else if (!visible)
			mode = lcd_pkg::MODE_VBLANK;
		else if (h_cnt <= lcd_pkg::OAM_LEN)
			mode = lcd_pkg::MODE_OAM;
		else if (h_cnt >= hblank_h)
			mode = lcd_pkg::MODE_HBLANK;
		else
			mode = lcd_pkg::MODE_XFER;
	end

	// ----------------------------------------------------------------------
	// interrupt sources, stat_ena[3:0] maps to stat bits 6..3
	assign src_lyc = stat_ena[3] && (h_cnt == 9'd2) && lyc_match;
	// oam and hblank phases only exist on visible lines
	assign src_oam = stat_ena[2] && (h_cnt == 9'd0) && visible;
	assign src_vbl = (h_cnt == lcd_pkg::LINE_LAST) && (ly == lcd_pkg::VBLANK_LINE - 8'd1);
	assign src_hbl = stat_ena[0] && (h_cnt == hblank_h) && visible;

	// one cycle pulses, registered after the condition
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			irq <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			irq <= src_lyc || src_oam || (stat_ena[1] && src_vbl) || src_hbl;
			vblank_irq <= src_vbl;
		end
	end

	// ----------------------------------------------------------------------
	a_hcnt_range: assert property (@(posedge clk_reg) disable iff (reset)
		h_cnt <= lcd_pkg::LINE_LAST)
		else $error("h_cnt past end of line");

	// sources sit on distinct line positions, so irq never merges
	a_irq_pulse: assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq)
		else $error("irq high for two cycles");

endmodule

// ==== hdl/oam_dma.sv ====
// oam dma sequencer
// copies 160 bytes from page*256 of system memory into oam,
// one byte every 4 cycles

`timescale 1ns/1ps

module oam_dma (
	input  logic        clk_reg,
	input  logic        reset,
	input  logic        dma_start,
	input  logic [7:0]  dma_page,
	input  logic [7:0]  dma_data,
	output logic        dma_active,
	output logic [15:0] dma_addr,
	output logic [7:0]  oam_waddr,
	output logic        oam_we
);

	logic [9:0] dma_cnt;

	// a new start always restarts from byte 0
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_active <= 1'b0;
			dma_cnt <= 10'd0;
		end else if (dma_start) begin
			dma_active <= 1'b1;
			dma_cnt <= 10'd0;
		end else if (dma_active) begin
			if (dma_cnt == lcd_pkg::DMA_LEN - 10'd1)
				dma_active <= 1'b0;
			else
				dma_cnt <= dma_cnt + 10'd1;
		end
	end

	// byte index is the counter over 4
	assign oam_waddr = dma_cnt[9:2];
	assign dma_addr = {dma_page, oam_waddr};
	// write mid-slot, memory data has settled by then
	assign oam_we = dma_active && (dma_cnt[1:0] == 2'd2);

	a_waddr_range: assert property (@(posedge clk_reg) disable iff (reset)
		oam_we |-> (oam_waddr < lcd_pkg::OAM_SIZE) && !$isunknown(dma_data))
		else $error("dma write outside oam or with unknown data");

endmodule

// ==== hdl/oam_ram.sv ====
// object attribute memory
// 160 bytes, dma writes take priority over cpu writes,
// cpu writes are locked out during oam scan and transfer

`timescale 1ns/1ps

module oam_ram (
	input  logic                clk_reg,
	input  logic                sel_oam,
	input  logic                cpu_wr,
	input  logic [7:0]          cpu_addr,
	input  logic [7:0]          cpu_di,
	input  lcd_pkg::mode_t      mode,
	input  logic                dma_active,
	input  logic                oam_we,
	input  logic [7:0]          oam_waddr,
	input  logic [7:0]          dma_data,
	output logic [7:0]          oam_do
);

	logic [7:0] mem [lcd_pkg::OAM_SIZE];
	logic [7:0] waddr;
	logic [7:0] wdata;
	logic       we;
	logic       cpu_ok;

	// modes 2 and 3 both have bit 1 set
	assign cpu_ok = sel_oam && cpu_wr && !mode[1] && (cpu_addr < lcd_pkg::OAM_SIZE);

	// dma owns the write port while it runs
	assign waddr = dma_active ? oam_waddr : cpu_addr;
	assign wdata = dma_active ? dma_data : cpu_di;
	assign we = dma_active ? oam_we : cpu_ok;

	always_ff @(posedge clk_reg) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// cpu sees 0xff beyond the table and while dma is busy
	assign oam_do = (dma_active || cpu_addr >= lcd_pkg::OAM_SIZE) ? 8'hFF : mem[cpu_addr];

endmodule

// ==== sources.f ====
+incdir+testbench
hdl/lcd_pkg.sv
hdl/lcd_timing.sv
hdl/lcd_regs.sv
hdl/oam_dma.sv
hdl/oam_ram.sv
hdl/lcd_ctrl.sv
testbench/tb_lcd_ctrl.sv

// ==== testbench/tb_lcd_checks.svh ====
	// lcd controller testbench helpers
	// compare tasks for each result type and the dma source memory model

	// ----------------------------------------------------------------------
	// system memory behind the dma port
	// each byte is the low address byte xor the high byte
	function automatic logic [7:0] src_byte(input logic [15:0] addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	// ----------------------------------------------------------------------
	// cpu_do for register and oam reads
	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s read %02h, expected %02h", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	// stat mode output of the top level
	task automatic check_mode(input lcd_pkg::mode_t got, input lcd_pkg::mode_t exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s is %0d, expected %0d", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	// single bit outputs such as lcd_on
	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s is %0b, expected %0b", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	// dma address bus toward system memory
	task automatic check_addr(input logic [15:0] got, input logic [15:0] exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s is %04h, expected %04h", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	// interrupt pulses or dma_rd cycles seen since the last rebase
	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[ERROR] %0d ns %s counted %0d, expected %0d", $time, what, got, exp);
			end_in_failure();
		end
	endtask

// ==== testbench/tb_lcd_ctrl.sv ====
// testbench for the lcd controller
// a table of cpu accesses, waits and checks covering the registers,
// line timing, interrupts and oam dma, applied in one loop

`timescale 1ns/1ps

module tb_lcd_ctrl;

	typedef enum logic [3:0] {
		OP_WREG, OP_RREG, OP_WOAM, OP_ROAM, OP_WAIT, OP_MODE, OP_CLR, OP_CNT, OP_DADDR
	} op_e;

	// for count checks addr selects irq (0), vblank_irq (1) or dma_rd cycles (2)
	typedef struct packed {
		op_e        op;
		logic [7:0] addr;
		logic [7:0] data;
		int         cycles;
		int         exp_val;
	} step_t;

	logic           clk_reg;
	logic           reset;
	logic           sel_reg;
	logic           sel_oam;
	logic           cpu_wr;
	logic [7:0]     cpu_addr;
	logic [7:0]     cpu_di;
	logic [7:0]     dma_data;
	logic [7:0]     cpu_do;
	logic           dma_rd;
	logic           irq;
	logic           vblank_irq;
	logic           lcd_on;
	logic [15:0]    dma_addr;
	lcd_pkg::mode_t mode;

	step_t steps[$];
	int    pulse_cnt [3];
	int    pulse_base [3];
	int    cycles_run;
	int    cycle_limit;
	int    err_cnt;

	lcd_ctrl u_lcd_ctrl (
		.clk_reg(clk_reg), .reset(reset), .sel_reg(sel_reg), .sel_oam(sel_oam),
		.cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_di(cpu_di), .dma_data(dma_data),
		.cpu_do(cpu_do), .dma_rd(dma_rd), .irq(irq), .vblank_irq(vblank_irq),
		.lcd_on(lcd_on), .dma_addr(dma_addr), .mode(mode)
	);

	task automatic end_in_failure();
		err_cnt++;
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	`include "tb_lcd_checks.svh"

	// memory answers in the same cycle
	assign dma_data = src_byte(dma_addr);

	// 100 ns period
	initial begin
		clk_reg = 1'b0;
		forever #50 clk_reg = ~clk_reg;
	end

	// ----------------------------------------------------------------------
	// pulse and cycle counters, sampled on the edge after the output rose
	always @(posedge clk_reg) begin
		if (irq)
			pulse_cnt[0] <= pulse_cnt[0] + 1;
		if (vblank_irq)
			pulse_cnt[1] <= pulse_cnt[1] + 1;
		if (dma_rd)
			pulse_cnt[2] <= pulse_cnt[2] + 1;
	end

	// run length guard, limit set once the table is built
	always @(posedge clk_reg) begin
		cycles_run <= cycles_run + 1;
		if (cycle_limit > 0 && cycles_run >= cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			end_in_failure();
		end
	end

	task automatic push_step(input op_e op, input logic [7:0] addr, input logic [7:0] data,
		input int cycles, input int exp_val);
		steps.push_back(step_t'{op, addr, data, cycles, exp_val});
	endtask

	// ----------------------------------------------------------------------
	// table contents, one cycle per access, waits take their own length
	task automatic build_table();
		logic [7:0] rt_addr [8];
		logic [7:0] val;
		logic [7:0] page;
		rt_addr = '{lcd_pkg::ADDR_SCY, lcd_pkg::ADDR_SCX, lcd_pkg::ADDR_WY, lcd_pkg::ADDR_WX,
			lcd_pkg::ADDR_BGP, lcd_pkg::ADDR_OBP0, lcd_pkg::ADDR_OBP1, lcd_pkg::ADDR_LYC};
		// reset values, stat has bit 7, ly == lyc and hblank
		push_step(OP_RREG, lcd_pkg::ADDR_LCDC, 8'h00, 0, 'h00);
		push_step(OP_RREG, lcd_pkg::ADDR_BGP, 8'h00, 0, 'hFC);
		push_step(OP_RREG, lcd_pkg::ADDR_OBP0, 8'h00, 0, 'hFF);
		push_step(OP_RREG, lcd_pkg::ADDR_STAT, 8'h00, 0, 'h84);
		push_step(OP_RREG, lcd_pkg::ADDR_LY, 8'h00, 0, 'h00);
		push_step(OP_RREG, 8'h50, 8'h00, 0, 'hFF);
		foreach (rt_addr[i]) begin
			val = 8'($urandom);
			push_step(OP_WREG, rt_addr[i], val, 0, 0);
			push_step(OP_RREG, rt_addr[i], 8'h00, 0, int'(val));
		end
		push_step(OP_WREG, lcd_pkg::ADDR_LYC, 8'h00, 0, 0);
		// lcd on, t counts from the edge after the write, line k spans 456k-4 onward
		push_step(OP_WREG, lcd_pkg::ADDR_LCDC, 8'h80, 0, 0);
		push_step(OP_WAIT, 8'h00, 8'h00, 200, 0);
		for (int k = 0; k < 4; k++) begin
			push_step(OP_RREG, lcd_pkg::ADDR_LY, 8'h00, 0, k);
			push_step(OP_WAIT, 8'h00, 8'h00, 455, 0);
		end
		// mid line 145 is vblank
		push_step(OP_WAIT, 8'h00, 8'h00, 456 * 141, 0);
		push_step(OP_MODE, 8'h00, 8'h00, 0, 1);
		push_step(OP_RREG, lcd_pkg::ADDR_STAT, 8'h00, 0, 'h81);
		push_step(OP_RREG, lcd_pkg::ADDR_LY, 8'h00, 0, 145);
		// one full frame with only the vblank stat source on
		push_step(OP_WREG, lcd_pkg::ADDR_STAT, 8'h10, 0, 0);
		push_step(OP_CLR, 8'h00, 8'h00, 0, 0);
		push_step(OP_WAIT, 8'h00, 8'h00, 154 * 456 - 1, 0);
		push_step(OP_CNT, 8'd1, 8'h00, 0, 1);
		push_step(OP_CNT, 8'd0, 8'h00, 0, 1);
		// lyc 10, restart the frame, check h 204 of lines 10 and 11 (mode 3)
		push_step(OP_WREG, lcd_pkg::ADDR_LYC, 8'd10, 0, 0);
		push_step(OP_WREG, lcd_pkg::ADDR_STAT, 8'h40, 0, 0);
		push_step(OP_CLR, 8'h00, 8'h00, 0, 0);
		push_step(OP_WREG, lcd_pkg::ADDR_LCDC, 8'h00, 0, 0);
		push_step(OP_WREG, lcd_pkg::ADDR_LCDC, 8'h80, 0, 0);
		push_step(OP_WAIT, 8'h00, 8'h00, 456 * 10 + 200, 0);
		push_step(OP_RREG, lcd_pkg::ADDR_STAT, 8'h00, 0, 'hC7);
		push_step(OP_WAIT, 8'h00, 8'h00, 455, 0);
		push_step(OP_RREG, lcd_pkg::ADDR_STAT, 8'h00, 0, 'hC3);
		push_step(OP_CNT, 8'd0, 8'h00, 0, 1);
		// dma from a random page with the lcd off
		page = 8'($urandom);
		push_step(OP_WREG, lcd_pkg::ADDR_LCDC, 8'h00, 0, 0);
		push_step(OP_WREG, lcd_pkg::ADDR_DMA, page, 0, 0);
		push_step(OP_CLR, 8'h00, 8'h00, 0, 0);
		push_step(OP_WAIT, 8'h00, 8'h00, 100, 0);
		// 100 cycles into the copy, byte 25 is on the bus
		push_step(OP_DADDR, 8'h00, 8'h00, 0, int'({page, 8'd25}));
		push_step(OP_WAIT, 8'h00, 8'h00, 599, 0);
		push_step(OP_CNT, 8'd2, 8'h00, 0, 640);
		push_step(OP_RREG, lcd_pkg::ADDR_DMA, 8'h00, 0, int'(page));
		for (int i = 0; i < 160; i++)
			push_step(OP_ROAM, 8'(i), 8'h00, 0, int'(page ^ 8'(i)));
		// cpu oam write in the oam scan is dropped, in hblank it lands
		push_step(OP_WREG, lcd_pkg::ADDR_LCDC, 8'h80, 0, 0);
		push_step(OP_WAIT, 8'h00, 8'h00, 10, 0);
		push_step(OP_MODE, 8'h00, 8'h00, 0, 2);
		push_step(OP_WOAM, 8'd5, ~(page ^ 8'd5), 0, 0);
		push_step(OP_ROAM, 8'd5, 8'h00, 0, int'(page ^ 8'd5));
		push_step(OP_WAIT, 8'h00, 8'h00, 337, 0);
		push_step(OP_MODE, 8'h00, 8'h00, 0, 0);
		push_step(OP_WOAM, 8'd5, page ^ 8'h39, 0, 0);
		push_step(OP_ROAM, 8'd5, 8'h00, 0, int'(page ^ 8'h39));
		// lcd still on at the end
		push_step(OP_RREG, lcd_pkg::ADDR_LCDC, 8'h00, 0, 'h80);
	endtask

	// ----------------------------------------------------------------------
	// drive on the rising edge, check at the falling edge
	task automatic run_step(input step_t s);
		@(posedge clk_reg);
		sel_reg <= (s.op == OP_WREG) || (s.op == OP_RREG);
		sel_oam <= (s.op == OP_WOAM) || (s.op == OP_ROAM);
		cpu_wr <= (s.op == OP_WREG) || (s.op == OP_WOAM);
		cpu_addr <= s.addr;
		cpu_di <= s.data;
		@(negedge clk_reg);
		case (s.op)
			OP_RREG, OP_ROAM: begin
				check_byte(cpu_do, s.exp_val[7:0], $sformatf("%s at %02h", s.op.name(), s.addr));
				// lcd_on output follows bit 7 of lcdc
				if (s.op == OP_RREG && s.addr == lcd_pkg::ADDR_LCDC)
					check_flag(lcd_on, s.exp_val[7], "lcd_on output");
			end
			OP_MODE:
				check_mode(mode, s.exp_val[1:0], "mode output");
			OP_DADDR:
				check_addr(dma_addr, s.exp_val[15:0], "dma_addr output");
			OP_CLR:
				pulse_base = pulse_cnt;
			OP_CNT: begin
				check_count(pulse_cnt[s.addr[1:0]] - pulse_base[s.addr[1:0]], s.exp_val,
					$sformatf("counter %0d", s.addr));
				pulse_base[s.addr[1:0]] = pulse_cnt[s.addr[1:0]];
			end
			OP_WAIT:
				repeat (s.cycles - 1) @(posedge clk_reg);
			default: ;
		endcase
	endtask

	initial begin
		int total;
		reset = 1'b1;
		sel_reg = 1'b0;
		sel_oam = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = 8'h00;
		cpu_di = 8'h00;
		void'($urandom(32'h730a));
		build_table();
		total = 0;
		foreach (steps[i])
			total += steps[i].cycles;
		cycle_limit = total + 1000;
		repeat (4) @(posedge clk_reg);
		reset <= 1'b0;
		foreach (steps[i])
			run_step(steps[i]);
		@(posedge clk_reg);
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			end_in_failure();
		end
	end

endmodule
